//--- src.f
hdl/picc_init_pkg.sv
hdl/cascade_uid_gen.sv
hdl/rx_frame_capture.sv
hdl/picc_state_ctrl.sv
hdl/reply_shifter.sv
hdl/picc_init_top.sv
tb/tb_clock_gen.sv
tb/picc_init_chk.sv
tb/picc_init_tb.sv

//--- tb/picc_init_tb.sv
// ==============================
// picc_init_tb
// frame level stimulus and reply checks
// for the type a init responder
// ==============================

`default_nettype none

module picc_init_tb;

    import picc_init_pkg::*;

    logic     clk;
    logic     rst_n;
    uid_t     uid;
    logic     rx_soc;
    logic     rx_eoc;
    byte_t    rx_data;
    bit_cnt_t rx_data_bits;
    logic     rx_data_valid;
    logic     rx_error;
    logic     rx_crc_ok;
    logic     tx_req;
    byte_t    tx_data;
    bit_cnt_t tx_data_bits;
    logic     tx_ready_to_send;
    logic     tx_append_crc;

    integer   seed;
    // per cascade level: four uid word bytes then bcc
    byte_t    lvl [2][5];
    byte_t    frame_q [$];
    byte_t    exp_q [$];
    byte_t    reply_q [$];
    bit_cnt_t first_bits;
    logic     crc_flag;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    picc_init_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .uid              (uid),
        .rx_soc           (rx_soc),
        .rx_eoc           (rx_eoc),
        .rx_data          (rx_data),
        .rx_data_bits     (rx_data_bits),
        .rx_data_valid    (rx_data_valid),
        .rx_error         (rx_error),
        .rx_crc_ok        (rx_crc_ok),
        .tx_req           (tx_req),
        .tx_data          (tx_data),
        .tx_data_bits     (tx_data_bits),
        .tx_ready_to_send (tx_ready_to_send),
        .tx_append_crc    (tx_append_crc)
    );

    // ==============================
    // reporting
    // ==============================

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            stop_with_failure($sformatf("CHECK FAILED time %0t: %s expected 0x%0h got 0x%0h",
                                        $time, name, exp, got));
        end
    endtask

    // watch the bound tx checker every cycle
    always @(negedge clk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            stop_with_failure("a bound assertion on the tx outputs failed");
        end
    end

    // ==============================
    // expected uid data
    // ==============================

    // level 1 is the cascade tag and uid bytes 0 to 2, level 2 is bytes 3 to 6
    function automatic void fill_levels();
        lvl[0][0] = CASCADE_TAG;
        for (int i = 0; i < 3; i++) begin
            lvl[0][i + 1] = uid[8 * i +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            lvl[1][i] = uid[8 * (i + 3) +: 8];
        end
        for (int l = 0; l < 2; l++) begin
            lvl[l][4] = lvl[l][0] ^ lvl[l][1] ^ lvl[l][2] ^ lvl[l][3];
        end
    endfunction

    // ==============================
    // receiver side
    // ==============================

    // soc, bytes of frame_q, then eoc; a partial last byte carries eoc itself
    task automatic send_frame(input bit_cnt_t last_bits, input logic crc_ok, input logic err);
        int n;
        n = frame_q.size();
        @(negedge clk);
        rx_soc    = 1'b1;
        rx_crc_ok = crc_ok;
        @(negedge clk);
        rx_soc = 1'b0;
        for (int i = 0; i < n; i++) begin
            rx_data_valid = 1'b1;
            rx_data       = frame_q[i];
            rx_data_bits  = (i == n - 1) ? last_bits : 3'd0;
            rx_eoc        = (i == n - 1) && (last_bits != '0);
            rx_error      = err && (i == 1);
            @(negedge clk);
        end
        rx_data_valid = 1'b0;
        rx_error      = 1'b0;
        rx_data_bits  = '0;
        if (last_bits == '0) begin
            rx_eoc = 1'b1;
            @(negedge clk);
        end
        rx_eoc = 1'b0;
    endtask

    task automatic send_short(input logic [6:0] cmd);
        frame_q = {byte_t'({1'b0, cmd})};
        send_frame(3'd7, 1'b0, 1'b0);
    endtask

    // flip is applied to the partial byte only
    task automatic send_anticoll(input int cl, input int nb, input int nbits, input byte_t flip);
        byte_t mask;
        mask    = 8'hff >> (8 - nbits);
        frame_q = {(cl == 0) ? SEL_CL1 : SEL_CL2, byte_t'((nb << 4) | nbits)};
        for (int i = 0; i < nb - 2; i++) begin
            frame_q.push_back(lvl[cl][i]);
        end
        if (nbits != 0) begin
            frame_q.push_back((lvl[cl][nb - 2] ^ flip) & mask);
        end
        send_frame(bit_cnt_t'(nbits), 1'b0, 1'b0);
    endtask

    // ==============================
    // transmitter side
    // ==============================

    task automatic wait_ready(input int limit, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clk);
            seen = tx_ready_to_send;
        end
    endtask

    task automatic collect_reply();
        logic seen;
        int   pulls;
        reply_q = {};
        wait_ready(20, seen);
        if (!seen) begin
            stop_with_failure("no reply: tx_ready_to_send did not rise in time");
        end
        // room for the anticollision alignment
        repeat (8) @(negedge clk);
        first_bits = tx_data_bits;
        crc_flag   = tx_append_crc;
        pulls      = 0;
        while (tx_ready_to_send) begin
            if (pulls == 8) begin
                stop_with_failure("reply did not end after 8 bytes");
            end
            reply_q.push_back(tx_data);
            tx_req = 1'b1;
            @(negedge clk);
            tx_req = 1'b0;
            @(negedge clk);
            pulls++;
        end
    endtask

    task automatic check_reply(input int exp_bits, input logic exp_crc);
        check_value("reply length", reply_q.size(), exp_q.size());
        check_value("tx_data_bits", first_bits, exp_bits);
        check_value("tx_append_crc", crc_flag, exp_crc);
        foreach (exp_q[i]) begin
            check_value($sformatf("tx_data[%0d]", i), reply_q[i], exp_q[i]);
        end
    endtask

    task automatic expect_no_reply();
        logic seen;
        wait_ready(20, seen);
        assert (!seen) else stop_with_failure("unexpected reply: tx_ready_to_send rose");
    endtask

    task automatic expect_atqa();
        exp_q = {8'h44, 8'h00};
        collect_reply();
        check_reply(0, 1'b0);
    endtask

    // the card returns what the reader has not sent yet
    task automatic anticoll_reply(input int cl, input int nb, input int nbits);
        send_anticoll(cl, nb, nbits, 8'h00);
        exp_q = {lvl[cl][nb - 2] >> nbits};
        for (int i = nb - 1; i < 5; i++) begin
            exp_q.push_back(lvl[cl][i]);
        end
        collect_reply();
        check_reply((8 - nbits) % 8, 1'b0);
    endtask

    task automatic select_reply(input int cl, input byte_t sak);
        frame_q = {(cl == 0) ? SEL_CL1 : SEL_CL2, NVB_SELECT};
        for (int i = 0; i < 5; i++) begin
            frame_q.push_back(lvl[cl][i]);
        end
        send_frame(3'd0, 1'b1, 1'b0);
        exp_q = {sak};
        collect_reply();
        check_reply(0, 1'b1);
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        logic [63:0] rand_bits;
        int          waits;
        rx_soc        = 1'b0;
        rx_eoc        = 1'b0;
        rx_data       = '0;
        rx_data_bits  = '0;
        rx_data_valid = 1'b0;
        rx_error      = 1'b0;
        rx_crc_ok     = 1'b0;
        tx_req        = 1'b0;
        seed          = 32'ha1e8727b;
        rand_bits     = {$random(seed), $random(seed)};
        uid           = rand_bits[55:0];
        fill_levels();

        // rst_n may still be unknown at time 0
        waits = 0;
        while (rst_n !== 1'b1) begin
            if (waits == 10) begin
                stop_with_failure("reset was not released");
            end
            @(negedge clk);
            waits++;
        end

        // reqa from idle
        send_short(CMD_REQA);
        expect_atqa();

        // full and partial anticollision at level 1
        anticoll_reply(0, 2, 0);
        anticoll_reply(0, 3, 5);
        anticoll_reply(0, 5, 2);
        // one wrong uid bit, card drops back to idle
        send_anticoll(0, 3, 5, 8'h01);
        expect_no_reply();

        // select through both levels
        send_short(CMD_REQA);
        expect_atqa();
        select_reply(0, 8'h04);
        anticoll_reply(1, 2, 0);
        select_reply(1, 8'h20);

        // halt in active, reqa ignored, wupa wakes
        frame_q = {CMD_HLTA[7:0], CMD_HLTA[15:8]};
        send_frame(3'd0, 1'b1, 1'b0);
        expect_no_reply();
        send_short(CMD_REQA);
        expect_no_reply();
        send_short(CMD_WUPA);
        expect_atqa();

        // receive error in ready
        frame_q = {SEL_CL1, 8'h20};
        send_frame(3'd0, 1'b0, 1'b1);
        expect_no_reply();
        send_anticoll(0, 2, 0, 8'h00);
        expect_no_reply();

        repeat (4) @(negedge clk);
        if (dut_i.chk_i.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("a bound assertion on the tx outputs failed");
        end
    end

endmodule

`default_nettype wire

//--- tb/picc_init_chk.sv
// ==============================
// picc_init_chk
// concurrent checks on the transmitter side
// ==============================

`default_nettype none

module picc_init_chk (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          rx_eoc,
    input wire                          tx_req,
    input wire                          tx_ready_to_send,
    input wire picc_init_pkg::bit_cnt_t tx_data_bits,
    input wire                          tx_append_crc
);

    // read by the testbench top
    int unsigned fail_count = 0;

    // a reply is offered a fixed two cycles after the frame ends
    ready_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_ready_to_send) |-> $past(rx_eoc, 2))
    else begin
        fail_count++;
        $error("tx_ready_to_send rose without rx_eoc two cycles before");
    end

    // crc is only appended to the one byte sak
    crc_single_byte_a: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_ready_to_send && tx_append_crc && tx_req) |=> !tx_ready_to_send)
    else begin
        fail_count++;
        $error("reply with tx_append_crc is longer than one byte");
    end

    // only the first transfer may be partial
    full_bytes_after_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_ready_to_send && tx_req) |=> (tx_data_bits == '0))
    else begin
        fail_count++;
        $error("tx_data_bits not zero after tx_req");
    end

endmodule

bind picc_init_top picc_init_chk chk_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .rx_eoc           (rx_eoc),
    .tx_req           (tx_req),
    .tx_ready_to_send (tx_ready_to_send),
    .tx_data_bits     (tx_data_bits),
    .tx_append_crc    (tx_append_crc)
);

`default_nettype wire

//--- tb/tb_clock_gen.sv
// ==============================
// tb_clock_gen
// testbench clock and active low reset
// ==============================

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/picc_init_top.sv
// ==============================
// picc_init_top
// iso 14443-3 type a init and anticollision
// responder, double size uid
// ==============================

`default_nettype none

module picc_init_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire picc_init_pkg::uid_t     uid,
    input  wire                          rx_soc,
    input  wire                          rx_eoc,
    input  wire picc_init_pkg::byte_t    rx_data,
    input  wire picc_init_pkg::bit_cnt_t rx_data_bits,
    input  wire                          rx_data_valid,
    input  wire                          rx_error,
    input  wire                          rx_crc_ok,
    input  wire                          tx_req,
    output picc_init_pkg::byte_t         tx_data,
    output picc_init_pkg::bit_cnt_t      tx_data_bits,
    output logic                         tx_ready_to_send,
    output logic                         tx_append_crc
);

    import picc_init_pkg::*;

    // rx side to control
    logic      pkt_received;
    logic      rx_error_flag;
    logic      uid_match;
    byte_t     cmd_byte0;
    byte_t     cmd_byte1;
    byte_t     nvb;

    // current cascade level data
    uid_word_t uid_word;
    byte_t     bcc;
    byte_t     sel_code;
    logic      final_level;

    // control outputs
    reply_t    reply;
    logic      cascade_clear;
    logic      cascade_advance;

    rx_frame_capture rx_frame_capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_soc        (rx_soc),
        .rx_eoc        (rx_eoc),
        .rx_data       (rx_data),
        .rx_data_bits  (rx_data_bits),
        .rx_data_valid (rx_data_valid),
        .rx_error      (rx_error),
        .uid_word      (uid_word),
        .bcc           (bcc),
        .pkt_received  (pkt_received),
        .rx_error_flag (rx_error_flag),
        .uid_match     (uid_match),
        .cmd_byte0     (cmd_byte0),
        .cmd_byte1     (cmd_byte1),
        .nvb           (nvb)
    );

    cascade_uid_gen cascade_uid_gen_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .uid             (uid),
        .cascade_clear   (cascade_clear),
        .cascade_advance (cascade_advance),
        .uid_word        (uid_word),
        .bcc             (bcc),
        .sel_code        (sel_code),
        .final_level     (final_level)
    );

    picc_state_ctrl picc_state_ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .pkt_received    (pkt_received),
        .rx_error_flag   (rx_error_flag),
        .rx_crc_ok       (rx_crc_ok),
        .uid_match       (uid_match),
        .cmd_byte0       (cmd_byte0),
        .cmd_byte1       (cmd_byte1),
        .sel_code        (sel_code),
        .final_level     (final_level),
        .reply           (reply),
        .cascade_clear   (cascade_clear),
        .cascade_advance (cascade_advance)
    );

    reply_shifter reply_shifter_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .reply            (reply),
        .nvb              (nvb),
        .uid_word         (uid_word),
        .bcc              (bcc),
        .final_level      (final_level),
        .tx_req           (tx_req),
        .tx_data          (tx_data),
        .tx_data_bits     (tx_data_bits),
        .tx_ready_to_send (tx_ready_to_send),
        .tx_append_crc    (tx_append_crc)
    );

endmodule

`default_nettype wire

//--- hdl/reply_shifter.sv
// ==============================
// reply_shifter
// loads the reply buffer, aligns ac replies to the
// nvb and hands bytes to the transmitter on tx_req
// ==============================

`default_nettype none

module reply_shifter (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire picc_init_pkg::reply_t    reply,
    input  wire picc_init_pkg::byte_t     nvb,
    input  wire picc_init_pkg::uid_word_t uid_word,
    input  wire picc_init_pkg::byte_t     bcc,
    input  wire                           final_level,
    input  wire                           tx_req,
    output picc_init_pkg::byte_t          tx_data,
    output picc_init_pkg::bit_cnt_t       tx_data_bits,
    output logic                          tx_ready_to_send,
    output logic                          tx_append_crc
);

    import picc_init_pkg::*;

    byte_t    tx_buf [TX_BUF_LEN];
    // bytes left after the current one
    rx_idx_t  tx_count_m1;
    rx_idx_t  bytes_to_shift;
    bit_cnt_t bits_to_shift;
    rx_idx_t  nvb_bytes;
    bit_cnt_t nvb_bits;
    logic     next_byte;

    assign nvb_bytes = nvb[6:4];
    assign nvb_bits  = nvb[2:0];
    assign next_byte = tx_req && tx_ready_to_send && (tx_count_m1 != '0);
    assign tx_data   = tx_buf[0];

    // ==============================
    // buffer
    // ==============================

    always_ff @(posedge clk) begin
        // drop whole bytes first, then single bits, avoids a barrel shifter
        if (next_byte || (bytes_to_shift != '0)) begin
            for (int i = 0; i < TX_BUF_LEN - 1; i++) begin
                tx_buf[i] <= tx_buf[i + 1];
            end
        end else if (bits_to_shift != '0) begin
            tx_buf[0] <= {1'b0, tx_buf[0][7:1]};
        end

        case (reply)
            reply_atqa: begin
                tx_buf[0] <= ATQA_DOUBLE[7:0];
                tx_buf[1] <= ATQA_DOUBLE[15:8];
            end
            reply_ac: begin
                tx_buf[0] <= uid_word[7:0];
                tx_buf[1] <= uid_word[15:8];
                tx_buf[2] <= uid_word[23:16];
                tx_buf[3] <= uid_word[31:24];
                tx_buf[4] <= bcc;
            end
            reply_sak: begin
                tx_buf[0] <= final_level ? SAK_COMPLETE : SAK_NOT_COMPLETE;
            end
            default: begin
            end
        endcase
    end

    // ==============================
    // control
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_count_m1      <= '0;
            bytes_to_shift   <= '0;
            bits_to_shift    <= '0;
            tx_data_bits     <= '0;
            tx_ready_to_send <= 1'b0;
            tx_append_crc    <= 1'b0;
        end else begin
            if (bytes_to_shift != '0) begin
                bytes_to_shift <= bytes_to_shift - 3'd1;
            end else if (bits_to_shift != '0) begin
                bits_to_shift <= bits_to_shift - 3'd1;
            end

            if (tx_req && tx_ready_to_send) begin
                // only the first transfer can be partial
                tx_data_bits <= '0;
                if (tx_count_m1 != '0) begin
                    tx_count_m1 <= tx_count_m1 - 3'd1;
                end else begin
                    tx_ready_to_send <= 1'b0;
                end
            end

            // a new reply replaces anything still pending
            case (reply)
                reply_atqa: begin
                    tx_count_m1      <= 3'd1;
                    bytes_to_shift   <= '0;
                    bits_to_shift    <= '0;
                    tx_data_bits     <= '0;
                    tx_append_crc    <= 1'b0;
                    tx_ready_to_send <= 1'b1;
                end
                reply_ac: begin
                    // skip the uid bytes the pcd already sent
                    bytes_to_shift   <= nvb_bytes - 3'd2;
                    bits_to_shift    <= nvb_bits;
                    // first transfer holds 8 - nvb bits, 0 wraps to a full byte
                    tx_data_bits     <= 3'd0 - nvb_bits;
                    // 5 - (nvb bytes - 2) bytes left, minus one
                    tx_count_m1      <= 3'd6 - nvb_bytes;
                    tx_append_crc    <= 1'b0;
                    tx_ready_to_send <= 1'b1;
                end
                reply_sak: begin
                    tx_count_m1      <= '0;
                    bytes_to_shift   <= '0;
                    bits_to_shift    <= '0;
                    tx_data_bits     <= '0;
                    tx_append_crc    <= 1'b1;
                    tx_ready_to_send <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/picc_state_ctrl.sv
// ==============================
// picc_state_ctrl
// command decode and the picc state machine
// idle, ready, active with a separate halt flag
// ==============================

`default_nettype none

module picc_state_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       pkt_received,
    input  wire                       rx_error_flag,
    input  wire                       rx_crc_ok,
    input  wire                       uid_match,
    input  wire picc_init_pkg::byte_t cmd_byte0,
    input  wire picc_init_pkg::byte_t cmd_byte1,
    input  wire picc_init_pkg::byte_t sel_code,
    input  wire                       final_level,
    output picc_init_pkg::reply_t     reply,
    output logic                      cascade_clear,
    output logic                      cascade_advance
);

    import picc_init_pkg::*;

    picc_state_t state;
    picc_state_t next_state;
    logic        halted;
    logic        next_halted;

    logic is_reqa;
    logic is_wupa;
    logic is_hlta;
    logic is_ac_sel;
    logic is_select;
    logic is_anticoll;

    // ==============================
    // command decode
    // ==============================

    assign is_reqa     = (cmd_byte0[6:0] == CMD_REQA);
    assign is_wupa     = (cmd_byte0[6:0] == CMD_WUPA);
    assign is_hlta     = ({cmd_byte1, cmd_byte0} == CMD_HLTA) && rx_crc_ok;
    // sel code must be the one of our current level
    assign is_ac_sel   = (cmd_byte0 == sel_code);
    assign is_select   = is_ac_sel && (cmd_byte1 == NVB_SELECT) && rx_crc_ok;
    // a full nvb without good crc is not taken as anticollision
    assign is_anticoll = is_ac_sel && (cmd_byte1 != NVB_SELECT);

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            halted <= 1'b0;
        end else begin
            state  <= next_state;
            halted <= next_halted;
        end
    end

    // everything is decided in the pkt_received cycle
    always_comb begin
        next_state      = state;
        next_halted     = halted;
        reply           = reply_none;
        cascade_clear   = 1'b0;
        cascade_advance = 1'b0;

        if (pkt_received) begin
            if (rx_error_flag) begin
                // halt flag stays as it is
                next_state = st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        // halted cards only wake on wupa
                        if ((is_reqa && !halted) || is_wupa) begin
                            next_state    = st_ready;
                            reply         = reply_atqa;
                            cascade_clear = 1'b1;
                        end
                    end
                    st_ready: begin
                        if (is_select && uid_match) begin
                            reply = reply_sak;
                            if (final_level) begin
                                next_state = st_active;
                            end else begin
                                cascade_advance = 1'b1;
                            end
                        end else if (is_anticoll && uid_match) begin
                            reply = reply_ac;
                        end else begin
                            next_state = st_idle;
                        end
                    end
                    st_active: begin
                        // no iso 14443-4 layer, every frame ends the session
                        next_state = st_idle;
                        if (is_hlta) begin
                            next_halted = 1'b1;
                        end
                    end
                    default: begin
                        next_state = st_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_frame_capture.sv
// ==============================
// rx_frame_capture
// buffers received bytes, flags errors and compares
// the anticollision payload against the uid on the fly
// ==============================

`default_nettype none

module rx_frame_capture (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rx_soc,
    input  wire                          rx_eoc,
    input  wire picc_init_pkg::byte_t    rx_data,
    input  wire picc_init_pkg::bit_cnt_t rx_data_bits,
    input  wire                          rx_data_valid,
    input  wire                          rx_error,
    input  wire picc_init_pkg::uid_word_t uid_word,
    input  wire picc_init_pkg::byte_t    bcc,
    output logic                         pkt_received,
    output logic                         rx_error_flag,
    output logic                         uid_match,
    output picc_init_pkg::byte_t         cmd_byte0,
    output picc_init_pkg::byte_t         cmd_byte1,
    output picc_init_pkg::byte_t         nvb
);

    import picc_init_pkg::*;

    byte_t   rx_buf [RX_BUF_LEN];
    rx_idx_t rx_count;
    byte_t   exp_byte;
    byte_t   bit_mask;
    logic    byte_match;
    logic    buf_write;

    // ==============================
    // uid comparison
    // ==============================

    // bytes 0 and 1 are sel and nvb, uid starts at index 2
    always_comb begin
        case (rx_count)
            3'd2:    exp_byte = uid_word[7:0];
            3'd3:    exp_byte = uid_word[15:8];
            3'd4:    exp_byte = uid_word[23:16];
            3'd5:    exp_byte = uid_word[31:24];
            default: exp_byte = bcc;
        endcase
    end

    // only the received bits of a partial byte take part
    assign bit_mask = (rx_data_bits == '0) ? 8'hff
                                           : byte_t'((9'd1 << rx_data_bits) - 9'd1);
    assign byte_match = ((rx_data ^ exp_byte) & bit_mask) == '0;

    // ==============================
    // frame buffer
    // ==============================

    // extra bytes beyond the buffer (crc) are dropped
    assign buf_write = rx_data_valid && (rx_count != rx_idx_t'(RX_BUF_LEN));

    always_ff @(posedge clk) begin
        if (buf_write) begin
            rx_buf[rx_count] <= rx_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_count      <= '0;
            rx_error_flag <= 1'b0;
            uid_match     <= 1'b0;
            pkt_received  <= 1'b0;
        end else begin
            // buffer is complete one cycle after eoc
            pkt_received <= rx_eoc;

            if (rx_soc) begin
                rx_count      <= '0;
                rx_error_flag <= 1'b0;
                // assume a match until a byte says otherwise
                uid_match     <= 1'b1;
            end

            if (rx_error) begin
                rx_error_flag <= 1'b1;
            end

            if (buf_write) begin
                // a partial byte comes with eoc and is not counted,
                // so the count lines up with the nvb byte field
                if (!rx_eoc) begin
                    rx_count <= rx_count + 3'd1;
                end
                if ((rx_count > 3'd1) && !byte_match) begin
                    uid_match <= 1'b0;
                end
            end
        end
    end

    assign cmd_byte0 = rx_buf[0];
    assign cmd_byte1 = rx_buf[1];
    // nvb sits in the second byte of ac and select frames
    assign nvb       = rx_buf[1];

endmodule

`default_nettype wire

//--- hdl/cascade_uid_gen.sv
// ==============================
// cascade_uid_gen
// cascade level register, uid word, bcc and sel code
// ==============================

`default_nettype none

module cascade_uid_gen (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire picc_init_pkg::uid_t uid,
    input  wire                     cascade_clear,
    input  wire                     cascade_advance,
    output picc_init_pkg::uid_word_t uid_word,
    output picc_init_pkg::byte_t    bcc,
    output picc_init_pkg::byte_t    sel_code,
    output logic                    final_level
);

    import picc_init_pkg::*;

    cascade_t level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else if (cascade_clear) begin
            level <= '0;
        end else if (cascade_advance) begin
            level <= level + 1'b1;
        end
    end

    // level 0 carries the cascade tag in its first byte
    assign uid_word    = (level == '0) ? {uid[23:0], CASCADE_TAG} : uid[55:24];
    assign sel_code    = (level == '0) ? SEL_CL1 : SEL_CL2;
    assign final_level = (level != '0);

    // check byte over the four bytes of this level
    assign bcc = uid_word[31:24] ^ uid_word[23:16] ^ uid_word[15:8] ^ uid_word[7:0];

endmodule

`default_nettype wire

//--- hdl/picc_init_pkg.sv
// ==============================
// picc_init_pkg
// shared widths, command codes and reply constants
// for the iso 14443-3 type a init responder
// ==============================

`default_nettype none

package picc_init_pkg;

    // ==============================
    // widths
    // ==============================

    // one frame byte, lsb first on the wire
    typedef logic [7:0]  byte_t;
    // valid bits in a partial byte, 0 means a full byte
    typedef logic [2:0]  bit_cnt_t;
    // double size uid, 7 bytes
    typedef logic [55:0] uid_t;
    // uid part of one cascade level
    typedef logic [31:0] uid_word_t;
    // byte index into the rx buffer, also used for byte counts
    typedef logic [2:0]  rx_idx_t;
    // cascade level, only two with a double uid
    typedef logic [0:0]  cascade_t;

    typedef enum logic [1:0] {
        st_idle,
        st_ready,
        st_active
    } picc_state_t;

    typedef enum logic [1:0] {
        reply_none,
        reply_atqa,
        reply_ac,
        reply_sak
    } reply_t;

    // ==============================
    // buffer sizes and codes
    // ==============================

    // longest frame kept is select, crc dropped
    localparam int RX_BUF_LEN = 7;
    // longest reply is four uid bytes plus bcc
    localparam int TX_BUF_LEN = 5;

    // short frames, 7 bits
    localparam logic [6:0]  CMD_REQA = 7'h26;
    localparam logic [6:0]  CMD_WUPA = 7'h52;
    // hlta, low byte goes first
    localparam logic [15:0] CMD_HLTA = 16'h0050;

    localparam byte_t SEL_CL1     = 8'h93;
    localparam byte_t SEL_CL2     = 8'h95;
    localparam byte_t CASCADE_TAG = 8'h88;

    // bit frame anticollision, double uid size
    localparam logic [15:0] ATQA_DOUBLE = 16'h0044;

    localparam byte_t SAK_NOT_COMPLETE = 8'h04;
    localparam byte_t SAK_COMPLETE     = 8'h20;
    // nvb of a full select, 7 bytes 0 bits
    localparam byte_t NVB_SELECT       = 8'h70;

endpackage

`default_nettype wire
